//--- anti_alias_fir.sv
module anti_alias_fir (
    input  logic                                   audio_clk,
    input  logic                                   rst_in,
    input  logic                                   sample_strobe,
    input  logic signed [audio_pkg::sample_width-1:0] sample_in,
    output logic                                   fir_valid,
    output logic signed [audio_pkg::sample_width-1:0] fir_sample
);

    logic signed [audio_pkg::sample_width-1:0] delay_line [fir_pkg::num_taps];

    logic                                      mac_active;
    logic                                      mac_done;
    logic [fir_pkg::tap_width-1:0]             tap_idx;
    logic signed [fir_pkg::acc_width-1:0]      acc;
    logic signed [fir_pkg::acc_width-1:0]      acc_shift;

    logic signed [audio_pkg::sample_width-1:0] tap_sample;
    logic signed [fir_pkg::coef_width-1:0]     tap_coef;
    logic signed [audio_pkg::sample_width+fir_pkg::coef_width-1:0] product;
    logic signed [audio_pkg::sample_width-1:0] sat_sample;

    // newest sample sits at index 0 and meets coefficient 0.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            for (int i = 0; i < fir_pkg::num_taps; i++) begin
                delay_line[i] <= '0;
            end
        end else if (sample_strobe) begin
            delay_line[0] <= sample_in;
            for (int i = fir_pkg::num_taps - 1; i > 0; i--) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    assign tap_sample = delay_line[tap_idx];
    assign tap_coef   = fir_pkg::fir_coefs[tap_idx];
    assign product    = tap_sample * tap_coef;

    // the sequencer runs sixteen MAC cycles and then one cycle to saturate and strobe.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            mac_active <= 1'b0;
            mac_done   <= 1'b0;
            tap_idx    <= '0;
            fir_valid  <= 1'b0;
        end else begin
            fir_valid <= 1'b0;
            mac_done  <= 1'b0;
            if (sample_strobe) begin
                mac_active <= 1'b1;
                tap_idx    <= '0;
            end else if (mac_active) begin
                tap_idx <= tap_idx + 1'b1;
                if (tap_idx == fir_pkg::last_tap) begin
                    mac_active <= 1'b0;
                    mac_done   <= 1'b1;
                end
            end
            if (mac_done) begin
                fir_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (sample_strobe) begin
            acc <= '0;
        end else if (mac_active) begin
            acc <= acc + product;
        end
    end

    // Q15 back to integer by an arithmetic shift, which rounds toward minus infinity.
    assign acc_shift = acc >>> fir_pkg::coef_frac;

    always_comb begin
        if (acc_shift > audio_pkg::sample_max) begin
            sat_sample = audio_pkg::sample_max;
        end else if (acc_shift < audio_pkg::sample_min) begin
            sat_sample = audio_pkg::sample_min;
        end else begin
            sat_sample = acc_shift[audio_pkg::sample_width-1:0];
        end
    end

    always_ff @(posedge audio_clk) begin
        if (mac_done) begin
            fir_sample <= sat_sample;
        end
    end

endmodule

//--- audio_pkg.sv
package audio_pkg;

    // microphone samples are signed two's complement.
    localparam int sample_width = 16;

    localparam logic signed [sample_width-1:0] sample_max = {1'b0, {(sample_width - 1){1'b1}}};
    localparam logic signed [sample_width-1:0] sample_min = {1'b1, {(sample_width - 1){1'b0}}};

    // the DC offset is the mean of 2**offset_log2 samples.
    localparam int offset_log2 = 6;
    localparam int offset_acc_width = sample_width + offset_log2;

    // output rate is the input rate divided by decim_factor.
    localparam int decim_factor = 2;
    localparam int decim_phase_width = $clog2(decim_factor);
    localparam logic [decim_phase_width-1:0] decim_last =
        decim_phase_width'(decim_factor - 1);

endpackage

//--- calculate_offset.sv
module calculate_offset (
    input  logic                                   audio_clk,
    input  logic                                   rst_in,
    input  logic                                   offset_trigger,
    input  logic                                   sample_strobe,
    input  logic signed [audio_pkg::sample_width-1:0] audio_in,
    output logic                                   offset_strobe,
    output logic signed [audio_pkg::sample_width-1:0] offset
);

    // low is idle, high is accumulating.
    logic                                          accumulating;
    logic [audio_pkg::offset_log2-1:0]             sample_count;
    logic signed [audio_pkg::offset_acc_width-1:0] acc;
    logic signed [audio_pkg::offset_acc_width-1:0] sum_next;

    assign sum_next = acc + audio_in;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            accumulating  <= 1'b0;
            sample_count  <= '0;
            offset_strobe <= 1'b0;
        end else begin
            offset_strobe <= 1'b0;
            if (!accumulating) begin
                if (offset_trigger) begin
                    accumulating <= 1'b1;
                    sample_count <= '0;
                end
            end else if (sample_strobe) begin
                sample_count <= sample_count + 1'b1;
                if (sample_count == '1) begin
                    accumulating  <= 1'b0;
                    offset_strobe <= 1'b1;
                end
            end
        end
    end

    // the accumulator restarts on the arming trigger.
    always_ff @(posedge audio_clk) begin
        if (!accumulating && offset_trigger) begin
            acc <= '0;
        end else if (accumulating && sample_strobe) begin
            acc <= sum_next;
        end
    end

    // dropping the low bits of the sum is the floor of the mean.
    always_ff @(posedge audio_clk) begin
        if (accumulating && sample_strobe && sample_count == '1) begin
            offset <= sum_next[audio_pkg::offset_acc_width-1:audio_pkg::offset_log2];
        end
    end

endmodule

//--- fir_pkg.sv
package fir_pkg;

    localparam int num_taps = 16;
    localparam int tap_width = $clog2(num_taps);
    localparam logic [tap_width-1:0] last_tap = tap_width'(num_taps - 1);

    // coefficients are signed Q15.
    localparam int coef_width = 16;
    localparam int coef_frac = 15;

    // wide enough for 16 full-scale products without overflow.
    localparam int acc_width = 36;

    // hamming-windowed sinc, cutoff near 10 kHz at 48 kHz.
    // the taps sum to 32762, just under unity gain.
    localparam logic signed [coef_width-1:0] fir_coefs [num_taps] = '{
        -16'sd43,   16'sd153,   16'sd349,  -16'sd354,
        -16'sd1737, -16'sd419,  16'sd5859,  16'sd12573,
        16'sd12573, 16'sd5859,  -16'sd419, -16'sd1737,
        -16'sd354,  16'sd349,   16'sd153,  -16'sd43
    };

    // one cycle to load, one MAC per tap, one to saturate and register.
    localparam int fir_latency = num_taps + 2;

endpackage

//--- process_audio.f
audio_pkg.sv
fir_pkg.sv
calculate_offset.sv
anti_alias_fir.sv
process_audio.sv
process_audio_tb.sv

//--- process_audio.sv
module process_audio (
    input  logic                                   audio_clk,
    input  logic                                   rst_in,
    input  logic                                   offset_trigger,
    input  logic                                   mic_data_valid,
    input  logic signed [audio_pkg::sample_width-1:0] mic_sample,
    output logic signed [audio_pkg::sample_width-1:0] raw_audio,
    output logic signed [audio_pkg::sample_width-1:0] processed_audio,
    output logic                                   processed_valid,
    output logic                                   offset_ready
);

    logic                                      sample_strobe;
    logic                                      offset_strobe;
    logic signed [audio_pkg::sample_width-1:0] offset;
    logic signed [audio_pkg::sample_width-1:0] offset_reg;
    logic signed [audio_pkg::sample_width-1:0] corrected_sample;
    logic                                      fir_valid;
    logic signed [audio_pkg::sample_width-1:0] fir_sample;
    logic [audio_pkg::decim_phase_width-1:0]   decim_phase;

    always_ff @(posedge audio_clk) begin
        if (mic_data_valid) begin
            raw_audio <= mic_sample;
        end
    end

    // the strobe is delayed so downstream logic sees the held sample.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= mic_data_valid;
        end
    end

    calculate_offset offset_i (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .offset_trigger (offset_trigger),
        .sample_strobe  (sample_strobe),
        .audio_in       (raw_audio),
        .offset_strobe  (offset_strobe),
        .offset         (offset)
    );

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            offset_reg   <= '0;
            offset_ready <= 1'b0;
        end else if (offset_strobe) begin
            offset_reg   <= offset;
            offset_ready <= 1'b1;
        end
    end

    // the difference wraps on overflow like a 16-bit hardware subtractor.
    assign corrected_sample = offset_ready ? raw_audio - offset_reg : raw_audio;

    anti_alias_fir fir_i (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .sample_strobe (sample_strobe),
        .sample_in     (corrected_sample),
        .fir_valid     (fir_valid),
        .fir_sample    (fir_sample)
    );

    // keep the filter output on phase zero and drop the others.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            decim_phase     <= '0;
            processed_valid <= 1'b0;
        end else begin
            processed_valid <= 1'b0;
            if (fir_valid) begin
                processed_valid <= (decim_phase == '0);
                decim_phase <= (decim_phase == audio_pkg::decim_last) ? '0 : decim_phase + 1'b1;
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (fir_valid && decim_phase == '0) begin
            processed_audio <= fir_sample;
        end
    end

endmodule

//--- process_audio_tb.sv
module process_audio_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int sample_gap = 24;
    // one cycle to hold, the filter latency, one cycle to decimate.
    localparam int out_latency = fir_pkg::fir_latency + 2;
    localparam int offset_len = 1 << audio_pkg::offset_log2;
    localparam int drain_timeout = 200;

    logic                                      audio_clk;
    logic                                      rst_in;
    logic                                      offset_trigger;
    logic                                      mic_data_valid;
    logic signed [audio_pkg::sample_width-1:0] mic_sample;
    logic signed [audio_pkg::sample_width-1:0] raw_audio;
    logic signed [audio_pkg::sample_width-1:0] processed_audio;
    logic                                      processed_valid;
    logic                                      offset_ready;

    int    value_errors;
    int    protocol_errors;
    int    outputs_checked;
    int    cycle;
    string test_name;

    logic signed [audio_pkg::sample_width-1:0] model_line [fir_pkg::num_taps];
    logic signed [audio_pkg::sample_width-1:0] model_offset;
    logic signed [audio_pkg::sample_width-1:0] last_raw;
    logic                                      model_ready;
    logic                                      model_cal;
    logic                                      have_raw;
    int                                        cal_count;
    int                                        cal_sum;
    int                                        decim_phase;
    int                                        exp_value_q [$];
    int                                        exp_cycle_q [$];

    process_audio dut_i (
        .audio_clk       (audio_clk),
        .rst_in          (rst_in),
        .offset_trigger  (offset_trigger),
        .mic_data_valid  (mic_data_valid),
        .mic_sample      (mic_sample),
        .raw_audio       (raw_audio),
        .processed_audio (processed_audio),
        .processed_valid (processed_valid),
        .offset_ready    (offset_ready)
    );

    initial begin
        audio_clk = 1'b0;
        forever #5 audio_clk = ~audio_clk;
    end

    function automatic logic signed [audio_pkg::sample_width-1:0] to_sample(input int value);
        return value[audio_pkg::sample_width-1:0];
    endfunction

    // Q15 dot product over the model delay line, floor shift, then clamp.
    function automatic int filter_model();
        longint acc;
        acc = 0;
        for (int k = 0; k < fir_pkg::num_taps; k++) begin
            acc += longint'(fir_pkg::fir_coefs[k]) * longint'(model_line[k]);
        end
        acc = acc >>> fir_pkg::coef_frac;
        if (acc > longint'(audio_pkg::sample_max)) begin
            acc = longint'(audio_pkg::sample_max);
        end else if (acc < longint'(audio_pkg::sample_min)) begin
            acc = longint'(audio_pkg::sample_min);
        end
        return int'(acc);
    endfunction

    // raw value whose corrected sample is full scale with the sign of the tap.
    function automatic logic signed [audio_pkg::sample_width-1:0] saturating_input(
        input int tap,
        input bit positive
    );
        int target;
        if ((fir_pkg::fir_coefs[tap] >= 0) == positive) begin
            target = int'(audio_pkg::sample_max);
        end else begin
            target = int'(audio_pkg::sample_min);
        end
        return to_sample(target + int'(model_offset));
    endfunction

    task automatic reset_model();
        for (int k = 0; k < fir_pkg::num_taps; k++) begin
            model_line[k] = '0;
        end
        model_offset = '0;
        model_ready  = 1'b0;
        model_cal    = 1'b0;
        cal_count    = 0;
        cal_sum      = 0;
        decim_phase  = 0;
        exp_value_q.delete();
        exp_cycle_q.delete();
    endtask

    task automatic model_sample(input logic signed [audio_pkg::sample_width-1:0] x);
        logic signed [audio_pkg::sample_width-1:0] corrected;
        int                                        mean;
        assert (offset_ready == model_ready) else begin
            value_errors++;
            $display("Fail %s: offset_ready expected %0d actual %0d",
                     test_name, model_ready, offset_ready);
        end
        corrected = model_ready ? x - model_offset : x;
        for (int k = fir_pkg::num_taps - 1; k > 0; k--) begin
            model_line[k] = model_line[k-1];
        end
        model_line[0] = corrected;
        if (decim_phase == 0) begin
            exp_value_q.push_back(filter_model());
            exp_cycle_q.push_back(cycle + out_latency);
        end
        decim_phase = (decim_phase + 1) % audio_pkg::decim_factor;
        if (model_cal) begin
            cal_sum += int'(x);
            cal_count++;
            if (cal_count == offset_len) begin
                mean         = cal_sum >>> audio_pkg::offset_log2;
                model_offset = to_sample(mean);
                model_ready  = 1'b1;
                model_cal    = 1'b0;
            end
        end
    endtask

    task automatic check_output();
        if (exp_cycle_q.size() > 0 && cycle > exp_cycle_q[0]) begin
            protocol_errors++;
            $display("%s: processed_valid did not arrive at cycle %0d", test_name, exp_cycle_q[0]);
            void'(exp_cycle_q.pop_front());
            void'(exp_value_q.pop_front());
        end
        if (processed_valid) begin
            if (exp_cycle_q.size() == 0) begin
                protocol_errors++;
                $display("%s: processed_valid came with no sample due at cycle %0d",
                         test_name, cycle);
            end else begin
                assert (cycle == exp_cycle_q[0]) else begin
                    value_errors++;
                    $display("Fail %s: output cycle expected %0d actual %0d",
                             test_name, exp_cycle_q[0], cycle);
                end
                assert (int'(processed_audio) == exp_value_q[0]) else begin
                    value_errors++;
                    $display("Fail %s: processed_audio expected %0d actual %0d",
                             test_name, exp_value_q[0], processed_audio);
                end
                void'(exp_cycle_q.pop_front());
                void'(exp_value_q.pop_front());
                outputs_checked++;
            end
        end
    endtask

    // the model samples inputs on the same edge as the DUT.
    always @(posedge audio_clk) begin
        cycle++;
        if (rst_in) begin
            reset_model();
        end else begin
            if (have_raw) begin
                assert (raw_audio == last_raw) else begin
                    value_errors++;
                    $display("Fail %s: raw_audio expected %0d actual %0d",
                             test_name, last_raw, raw_audio);
                end
            end
            check_output();
            if (offset_trigger && !model_cal) begin
                model_cal = 1'b1;
                cal_count = 0;
                cal_sum   = 0;
            end
            if (mic_data_valid) begin
                last_raw = mic_sample;
                have_raw = 1'b1;
                model_sample(mic_sample);
            end
        end
    end

    reset_clears_outputs: assert property (
        @(posedge audio_clk) rst_in |=> (!offset_ready && !processed_valid)
    ) else begin
        protocol_errors++;
        $display("%s: reset left offset_ready or processed_valid high", test_name);
    end

    single_cycle_valid: assert property (
        @(posedge audio_clk) disable iff (rst_in) processed_valid |=> !processed_valid
    ) else begin
        protocol_errors++;
        $display("%s: processed_valid stayed high for more than one cycle", test_name);
    end

    task automatic send_sample(input logic signed [audio_pkg::sample_width-1:0] value);
        @(posedge audio_clk);
        mic_data_valid <= 1'b1;
        mic_sample     <= value;
        @(posedge audio_clk);
        mic_data_valid <= 1'b0;
        repeat (sample_gap - 2) @(posedge audio_clk);
    endtask

    task automatic pulse_trigger();
        @(posedge audio_clk);
        offset_trigger <= 1'b1;
        @(posedge audio_clk);
        offset_trigger <= 1'b0;
    endtask

    initial begin
        int wait_count;
        rst_in          = 1'b1;
        offset_trigger  = 1'b0;
        mic_data_valid  = 1'b0;
        mic_sample      = '0;
        value_errors    = 0;
        protocol_errors = 0;
        outputs_checked = 0;
        cycle           = 0;
        have_raw        = 1'b0;
        test_name       = "reset";
        void'($urandom(32'hbd30_4196));
        repeat (10) @(posedge audio_clk);
        rst_in <= 1'b0;

        test_name = "impulse";
        send_sample(to_sample(16384));
        for (int i = 0; i < 2 * fir_pkg::num_taps; i++) begin
            send_sample('0);
        end

        test_name = "decimation";
        for (int i = 0; i < 40; i++) begin
            send_sample(to_sample(int'($urandom())));
        end

        // the second trigger lands halfway through accumulation.
        test_name = "offset_calibration";
        pulse_trigger();
        for (int i = 0; i < offset_len + 24; i++) begin
            if (i == offset_len / 2) begin
                pulse_trigger();
            end
            send_sample(to_sample(1000 + int'($urandom_range(32)) - 16));
        end

        test_name = "saturation";
        for (int i = 0; i < 48; i++) begin
            send_sample(to_sample(int'($urandom())));
        end
        for (int j = 0; j < fir_pkg::num_taps; j++) begin
            send_sample(saturating_input(j, 1'b1));
        end
        for (int j = 0; j < fir_pkg::num_taps; j++) begin
            send_sample(saturating_input(j, 1'b0));
        end

        test_name = "reset_midstream";
        send_sample(to_sample(int'($urandom())));
        // reset lands while the output strobe of the next sample is high.
        @(posedge audio_clk);
        mic_data_valid <= 1'b1;
        mic_sample     <= to_sample(int'($urandom()));
        @(posedge audio_clk);
        mic_data_valid <= 1'b0;
        repeat (out_latency - 1) @(posedge audio_clk);
        rst_in <= 1'b1;
        repeat (10) @(posedge audio_clk);
        rst_in <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            send_sample(to_sample(int'($urandom())));
        end

        test_name  = "drain";
        wait_count = 0;
        while (exp_cycle_q.size() > 0 && wait_count < drain_timeout) begin
            @(posedge audio_clk);
            wait_count++;
        end
        if (exp_cycle_q.size() > 0) begin
            protocol_errors++;
            $display("timed out with %0d filtered outputs still missing", exp_cycle_q.size());
        end
        if (outputs_checked == 0) begin
            protocol_errors++;
            $display("no filtered output was ever checked");
        end

        $display("errors: %0d value, %0d protocol (%0d outputs checked)",
                 value_errors, protocol_errors, outputs_checked);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=process_audio_sim
log_file=process_audio_sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found on the PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module process_audio_tb \
    -f process_audio.f \
    --Mdir "$build_dir" \
    -o "$sim_exe"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$log_file"; then
    echo "simulation passed, see $log_file"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi
